/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_cache_top
FILELIST  = cache_top.f
OBJ_DIR   = obj_dir
PASS_MSG  = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the simulator output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bus_pkg.sv */
// request and response bundles of the CPU port and the line memory port
package bus_pkg;

	// single word access from the CPU
	typedef struct packed {
		logic                   write;
		cache_pkg::cache_addr_u addr;
		logic [31:0]            wdata;
		logic [3:0]             be;     // byte enables
	} cpu_req_s;

	typedef struct packed {
		logic [31:0] rdata;
	} cpu_rsp_s;

	// whole line transfer, address is line aligned
	typedef struct packed {
		logic                          write;
		cache_pkg::cache_addr_u        addr;
		logic [cache_pkg::LINE_W-1:0]  wdata;
	} mem_req_s;

	// valid while the memory ack is high
	typedef struct packed {
		logic [cache_pkg::LINE_W-1:0] rdata;
	} mem_rsp_s;

endpackage

/* cache_control.sv */
// execute stage: FSM sequencing hits, write-back, refill and both four-phase handshakes
`timescale 1ns/1ps

module cache_control (
	input  logic                           clk,
	input  logic                           arst_n_i,
	input  bus_pkg::cpu_req_s              cpu_req_i,
	input  logic                           cpu_req_valid_i,
	output logic                           cpu_ack_o,
	output bus_pkg::cpu_rsp_s              cpu_rsp_o,
	input  logic                           hit_i,
	input  logic                           hit_way_i,
	input  logic                           victim_way_i,
	input  cache_pkg::way_info_s           victim_info_i,
	input  logic [cache_pkg::LINE_W-1:0]   victim_line_i,
	input  logic [31:0]                    read_word_i,
	output bus_pkg::mem_req_s              mem_req_o,
	output logic                           mem_req_valid_o,
	input  logic                           mem_ack_i,
	output logic                           write0_o,
	output logic                           write1_o,
	output logic                           set_dirty_o,
	output logic                           clear_dirty_o,
	output logic                           fill_sel_o,
	output logic                           lru_update_o,
	output logic                           used_way_o,
	output cache_pkg::cache_addr_u         req_addr_o
);

	typedef enum logic [2:0] {
		st_idle,
		st_lookup,
		st_compare,
		st_wb,
		st_wb_rel,
		st_refill,
		st_refill_rel,
		st_done
	} state_e;

	state_e state_q;
	state_e state_d;

	logic ack_q;
	logic mem_valid_q;
	logic way_q;        // way chosen at compare, held through a miss

	cache_pkg::cache_addr_u req_addr_q;
	logic                   req_write_q;
	bus_pkg::mem_req_s      mem_req_q;
	bus_pkg::cpu_rsp_s      rsp_q;

	cache_pkg::cache_addr_u victim_addr;
	cache_pkg::cache_addr_u refill_addr;

	logic cmp_hit;
	logic fill_now;
	logic way_wr;
	logic ld_wb;
	logic ld_rd;

	always_comb begin
		state_d = state_q;
		ld_wb   = 1'b0;
		ld_rd   = 1'b0;
		case (state_q)
			st_idle: begin
				if (cpu_req_valid_i) begin
					state_d = st_lookup;
				end
			end
			st_lookup: state_d = st_compare; // ways read the set here
			st_compare: begin
				if (hit_i) begin
					state_d = st_done;
				end else if (victim_info_i.valid && victim_info_i.dirty) begin
					state_d = st_wb;
					ld_wb   = 1'b1;
				end else begin
					state_d = st_refill;
					ld_rd   = 1'b1;
				end
			end
			st_wb: begin
				if (mem_ack_i) begin
					state_d = st_wb_rel;
				end
			end
			st_wb_rel: begin
				if (!mem_ack_i) begin
					state_d = st_refill;
					ld_rd   = 1'b1;
				end
			end
			st_refill: begin
				if (mem_ack_i) begin
					state_d = st_refill_rel;
				end
			end
			st_refill_rel: begin
				if (!mem_ack_i) begin
					state_d = st_lookup; // repeat lookup, now a hit
				end
			end
			st_done: begin
				if (!cpu_req_valid_i) begin
					state_d = st_idle;
				end
			end
			default: state_d = st_idle;
		endcase
	end

	// memory addresses of the victim line and the missing line
	always_comb begin
		victim_addr                 = req_addr_q;
		victim_addr.fields.tag      = victim_info_i.tag;
		victim_addr.fields.word     = '0;
		victim_addr.fields.byte_off = '0;
		refill_addr.raw = {req_addr_q.raw[31:cache_pkg::OFFSET_W], {cache_pkg::OFFSET_W{1'b0}}};
	end

	assign cmp_hit  = (state_q == st_compare) && hit_i;
	assign fill_now = (state_q == st_refill) && mem_ack_i; // line captured on first ack
	assign way_wr   = (cmp_hit && req_write_q) || fill_now;

	assign used_way_o    = (state_q == st_compare) ? (hit_i ? hit_way_i : victim_way_i) : way_q;
	assign write0_o      = way_wr && !used_way_o;
	assign write1_o      = way_wr && used_way_o;
	assign set_dirty_o   = cmp_hit;
	assign clear_dirty_o = fill_now;
	assign fill_sel_o    = (state_q == st_refill);
	assign lru_update_o  = cmp_hit;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q     <= st_idle;
			ack_q       <= 1'b0;
			mem_valid_q <= 1'b0;
			way_q       <= 1'b0;
		end else begin
			state_q     <= state_d;
			ack_q       <= (state_d == st_done);
			mem_valid_q <= (state_d == st_wb) || (state_d == st_refill);
			if (state_q == st_compare) begin
				way_q <= used_way_o;
			end
		end
	end

	always_ff @(posedge clk) begin
		if ((state_q == st_idle) && cpu_req_valid_i) begin
			req_addr_q  <= cpu_req_i.addr;
			req_write_q <= cpu_req_i.write;
		end
		if (ld_wb) begin
			mem_req_q.write <= 1'b1;
			mem_req_q.addr  <= victim_addr;
			mem_req_q.wdata <= victim_line_i;
		end else if (ld_rd) begin
			mem_req_q.write <= 1'b0;
			mem_req_q.addr  <= refill_addr;
		end
		if (cmp_hit) begin
			rsp_q.rdata <= read_word_i; // old word on a write hit
		end
	end

	assign cpu_ack_o       = ack_q;
	assign cpu_rsp_o       = rsp_q;
	assign mem_req_o       = mem_req_q;
	assign mem_req_valid_o = mem_valid_q;
	assign req_addr_o      = req_addr_q;

endmodule

/* cache_lookup.sv */
// decode stage: address split, tag compare against both ways and per-set LRU
`timescale 1ns/1ps

module cache_lookup (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  cache_pkg::cache_addr_u addr_i,
	input  cache_pkg::way_info_s   info0_i,
	input  cache_pkg::way_info_s   info1_i,
	input  logic                   lru_update_i,
	input  logic                   used_way_i,
	output logic                   hit_o,
	output logic                   hit_way_o,
	output logic                   victim_way_o,
	output cache_pkg::way_info_s   victim_info_o
);

	logic [cache_pkg::TAG_W-1:0]   req_tag;
	logic [cache_pkg::INDEX_W-1:0] req_set;
	logic                          hit0;
	logic                          hit1;

	// one bit per set, names the least recently used way
	logic [cache_pkg::NUM_SETS-1:0] lru_q;

	assign req_tag = addr_i.fields.tag;
	assign req_set = addr_i.fields.index;

	// compare on the registered way outputs
	assign hit0 = info0_i.valid && (info0_i.tag == req_tag);
	assign hit1 = info1_i.valid && (info1_i.tag == req_tag);

	assign hit_o     = hit0 || hit1;
	assign hit_way_o = hit1; // both ways never hold the same tag

	// replacement candidate and its state
	assign victim_way_o  = lru_q[req_set];
	assign victim_info_o = victim_way_o ? info1_i : info0_i;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			lru_q <= '0;
		end else if (lru_update_i) begin
			lru_q[req_set] <= ~used_way_i; // other way becomes LRU
		end
	end

endmodule

/* cache_pkg.sv */
// cache geometry and the address decode shared by the cache datapath
package cache_pkg;

	// two ways, eight sets, 32-byte lines
	localparam int OFFSET_W       = 5;
	localparam int INDEX_W        = 3;
	localparam int TAG_W          = 24;
	localparam int NUM_SETS       = 8;
	localparam int LINE_W         = 256;
	localparam int WORDS_PER_LINE = 8;

	localparam int LINE_BYTES = LINE_W / 8;               // one mask bit per byte
	localparam int WORD_SEL_W = $clog2(WORDS_PER_LINE);
	localparam int BYTE_SEL_W = OFFSET_W - WORD_SEL_W;    // byte within a word

	// field view of a 32-bit byte address
	typedef struct packed {
		logic [TAG_W-1:0]      tag;
		logic [INDEX_W-1:0]    index;
		logic [WORD_SEL_W-1:0] word;
		logic [BYTE_SEL_W-1:0] byte_off;
	} cache_addr_fields_s;

	// same word seen raw or split into fields
	typedef union packed {
		logic [31:0]        raw;
		cache_addr_fields_s fields;
	} cache_addr_u;

	// one way's tag state at the looked-up set
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic             valid;
		logic             dirty;
	} way_info_s;

endpackage

/* cache_response.sv */
// result stage: builds the line written into a way and selects the word read back
`timescale 1ns/1ps

module cache_response (
	input  bus_pkg::cpu_req_s                req_i,
	input  logic [cache_pkg::LINE_W-1:0]     way_line_i,
	input  logic [cache_pkg::LINE_W-1:0]     mem_line_i,
	input  logic                             fill_sel_i,
	output logic [cache_pkg::LINE_W-1:0]     line_o,
	output logic [cache_pkg::LINE_BYTES-1:0] byte_mask_o,
	output logic [31:0]                      read_word_o
);

	logic [cache_pkg::LINE_W-1:0]     cpu_line;
	logic [cache_pkg::LINE_BYTES-1:0] cpu_mask;

	// write word merged into its slot
	always_comb begin
		cpu_line = way_line_i;
		cpu_mask = '0;
		for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
			if (req_i.addr.fields.word == cache_pkg::WORD_SEL_W'(w)) begin
				for (int b = 0; b < 4; b++) begin
					cpu_mask[4*w + b] = req_i.be[b];
					if (req_i.be[b]) begin
						cpu_line[32*w + 8*b +: 8] = req_i.wdata[8*b +: 8];
					end
				end
			end
		end
	end

	// refill overwrites the whole line
	assign line_o      = fill_sel_i ? mem_line_i : cpu_line;
	assign byte_mask_o = fill_sel_i ? {cache_pkg::LINE_BYTES{1'b1}} : cpu_mask;

	assign read_word_o = way_line_i[32*req_i.addr.fields.word +: 32];

endmodule

/* cache_top.f */
cache_pkg.sv
bus_pkg.sv
cache_way.sv
cache_lookup.sv
cache_control.sv
cache_response.sv
cache_top.sv
tb_cache_mem.sv
tb_cache_top.sv

/* cache_top.sv */
// two-way write-back cache top: lookup, control, response and the two ways
`timescale 1ns/1ps

module cache_top (
	input  logic              clk,
	input  logic              arst_n_i,
	input  bus_pkg::cpu_req_s cpu_req_i,
	input  logic              cpu_req_valid_i,
	output logic              cpu_ack_o,
	output bus_pkg::cpu_rsp_s cpu_rsp_o,
	output bus_pkg::mem_req_s mem_req_o,
	output logic              mem_req_valid_o,
	input  logic              mem_ack_i,
	input  bus_pkg::mem_rsp_s mem_rsp_i
);

	cache_pkg::cache_addr_u req_addr;
	cache_pkg::way_info_s   info0;
	cache_pkg::way_info_s   info1;
	cache_pkg::way_info_s   victim_info;

	logic [cache_pkg::LINE_W-1:0]     line0;
	logic [cache_pkg::LINE_W-1:0]     line1;
	logic [cache_pkg::LINE_W-1:0]     sel_line;
	logic [cache_pkg::LINE_W-1:0]     wr_line;
	logic [cache_pkg::LINE_BYTES-1:0] wr_mask;
	logic [31:0]                      read_word;

	logic hit;
	logic hit_way;
	logic victim_way;
	logic lru_update;
	logic used_way;
	logic write0;
	logic write1;
	logic set_dirty;
	logic clear_dirty;
	logic fill_sel;

	assign sel_line = used_way ? line1 : line0; // hit way or victim

	cache_lookup i_lookup (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.addr_i        (req_addr),
		.info0_i       (info0),
		.info1_i       (info1),
		.lru_update_i  (lru_update),
		.used_way_i    (used_way),
		.hit_o         (hit),
		.hit_way_o     (hit_way),
		.victim_way_o  (victim_way),
		.victim_info_o (victim_info)
	);

	cache_control i_control (
		.clk             (clk),
		.arst_n_i        (arst_n_i),
		.cpu_req_i       (cpu_req_i),
		.cpu_req_valid_i (cpu_req_valid_i),
		.cpu_ack_o       (cpu_ack_o),
		.cpu_rsp_o       (cpu_rsp_o),
		.hit_i           (hit),
		.hit_way_i       (hit_way),
		.victim_way_i    (victim_way),
		.victim_info_i   (victim_info),
		.victim_line_i   (sel_line),
		.read_word_i     (read_word),
		.mem_req_o       (mem_req_o),
		.mem_req_valid_o (mem_req_valid_o),
		.mem_ack_i       (mem_ack_i),
		.write0_o        (write0),
		.write1_o        (write1),
		.set_dirty_o     (set_dirty),
		.clear_dirty_o   (clear_dirty),
		.fill_sel_o      (fill_sel),
		.lru_update_o    (lru_update),
		.used_way_o      (used_way),
		.req_addr_o      (req_addr)
	);

	// CPU request is held stable until ack
	cache_response i_response (
		.req_i       (cpu_req_i),
		.way_line_i  (sel_line),
		.mem_line_i  (mem_rsp_i.rdata),
		.fill_sel_i  (fill_sel),
		.line_o      (wr_line),
		.byte_mask_o (wr_mask),
		.read_word_o (read_word)
	);

	cache_way way0 (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.index_i       (req_addr.fields.index),
		.tag_i         (req_addr.fields.tag),
		.line_i        (wr_line),
		.byte_mask_i   (wr_mask),
		.write_i       (write0),
		.set_dirty_i   (set_dirty),
		.clear_dirty_i (clear_dirty),
		.info_o        (info0),
		.line_o        (line0)
	);

	cache_way way1 (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.index_i       (req_addr.fields.index),
		.tag_i         (req_addr.fields.tag),
		.line_i        (wr_line),
		.byte_mask_i   (wr_mask),
		.write_i       (write1),
		.set_dirty_i   (set_dirty),
		.clear_dirty_i (clear_dirty),
		.info_o        (info1),
		.line_o        (line1)
	);

endmodule

/* cache_way.sv */
// one cache way: line, tag, valid and dirty arrays with a byte-masked line write
`timescale 1ns/1ps

module cache_way (
	input  logic                                clk,
	input  logic                                arst_n_i,
	input  logic [cache_pkg::INDEX_W-1:0]       index_i,
	input  logic [cache_pkg::TAG_W-1:0]         tag_i,
	input  logic [cache_pkg::LINE_W-1:0]        line_i,
	input  logic [cache_pkg::LINE_BYTES-1:0]    byte_mask_i,
	input  logic                                write_i,
	input  logic                                set_dirty_i,
	input  logic                                clear_dirty_i,
	output cache_pkg::way_info_s                info_o,
	output logic [cache_pkg::LINE_W-1:0]        line_o
);

	logic [cache_pkg::LINE_W-1:0] data_q [cache_pkg::NUM_SETS];
	logic [cache_pkg::TAG_W-1:0]  tag_q  [cache_pkg::NUM_SETS];
	logic [cache_pkg::NUM_SETS-1:0] valid_q;
	logic [cache_pkg::NUM_SETS-1:0] dirty_q;

	logic [cache_pkg::TAG_W-1:0] rd_tag_q;
	logic                        rd_valid_q;
	logic                        rd_dirty_q;

	// data and tag storage, read registered every cycle
	always_ff @(posedge clk) begin
		if (write_i) begin
			for (int b = 0; b < cache_pkg::LINE_BYTES; b++) begin
				if (byte_mask_i[b]) begin
					data_q[index_i][8*b +: 8] <= line_i[8*b +: 8];
				end
			end
			tag_q[index_i] <= tag_i;
		end
		line_o   <= data_q[index_i]; // old contents on a write edge
		rd_tag_q <= tag_q[index_i];
	end

	// status bits
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_q    <= '0;
			dirty_q    <= '0;
			rd_valid_q <= 1'b0;
			rd_dirty_q <= 1'b0;
		end else begin
			if (write_i) begin
				valid_q[index_i] <= 1'b1; // any write installs the line
				if (set_dirty_i) begin
					dirty_q[index_i] <= 1'b1;
				end else if (clear_dirty_i) begin
					dirty_q[index_i] <= 1'b0;
				end
			end
			rd_valid_q <= valid_q[index_i];
			rd_dirty_q <= dirty_q[index_i];
		end
	end

	assign info_o = '{tag: rd_tag_q, valid: rd_valid_q, dirty: rd_dirty_q};

endmodule

/* tb_cache_mem.sv */
// behavioral line memory that answers the cache's four-phase memory handshake
`timescale 1ns/1ps

module tb_cache_mem (
	input  logic              clk,
	input  bus_pkg::mem_req_s mem_req_i,
	input  logic              mem_req_valid_i,
	output logic              mem_ack_o,
	output bus_pkg::mem_rsp_s mem_rsp_o
);

	localparam int RELEASE_TIMEOUT = 50; // cycles

	logic [cache_pkg::LINE_W-1:0] lines [logic [26:0]]; // sparse, keyed by line number
	logic [31:0]                  lfsr_q;

	// transfer log, read by the testbench
	int                           rd_count;
	int                           wb_count;
	int                           xfer_count;
	int                           last_rd_seq;
	int                           last_wb_seq;
	logic [31:0]                  last_rd_addr;
	logic [31:0]                  last_wb_addr;
	logic [cache_pkg::LINE_W-1:0] last_wb_line;
	logic                         proto_err;

	// initial contents, every address bit takes part
	function automatic logic [31:0] pattern_word(logic [31:0] addr);
		return {addr[15:0], addr[31:16]} ^ 32'h6b2dc5a7;
	endfunction

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_q[0]};
			lfsr_q = lfsr_next(lfsr_q); // one step per bit
		end
	endtask

	task automatic serve_request();
		logic [31:0]                  base;
		logic [cache_pkg::LINE_W-1:0] line;
		base = mem_req_i.addr.raw & 32'hffffffe0;
		xfer_count++;
		if (mem_req_i.write) begin
			lines[base[31:5]] = mem_req_i.wdata;
			wb_count++;
			last_wb_seq  = xfer_count;
			last_wb_addr = base;
			last_wb_line = mem_req_i.wdata;
		end else begin
			if (lines.exists(base[31:5])) begin
				line = lines[base[31:5]];
			end else begin
				for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
					line[32*w +: 32] = pattern_word(base + 4*w);
				end
			end
			mem_rsp_o.rdata = line;
			rd_count++;
			last_rd_seq  = xfer_count;
			last_rd_addr = base;
		end
	endtask

	initial begin
		logic [31:0] delay;
		int          waited;
		mem_ack_o  = 1'b0;
		mem_rsp_o  = '0;
		lfsr_q     = 32'h81d83a91;
		rd_count   = 0;
		wb_count   = 0;
		xfer_count = 0;
		proto_err  = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			if (mem_req_valid_i) begin
				draw_bits(3, delay); // 0 to 7 cycles
				for (int i = 0; i < int'(delay); i++) begin
					@(posedge clk);
					#1;
				end
				serve_request();
				mem_ack_o = 1'b1;
				waited = 0;
				do begin
					@(posedge clk);
					#1;
					waited++;
				end while (mem_req_valid_i && waited < RELEASE_TIMEOUT);
				if (mem_req_valid_i) begin
					proto_err = 1'b1;
				end
				mem_ack_o = 1'b0;
				mem_rsp_o = '0;
			end
		end
	end

endmodule

/* tb_cache_top.sv */
// testbench for the two-way cache: directed tests against a word reference model
`timescale 1ns/1ps

module tb_cache_top;

	localparam int ACK_TIMEOUT = 200; // cycles of write-back plus refill

	logic              clk;
	logic              arst_n;
	bus_pkg::cpu_req_s cpu_req;
	logic              cpu_req_valid;
	logic              cpu_ack;
	bus_pkg::cpu_rsp_s cpu_rsp;
	bus_pkg::mem_req_s mem_req;
	logic              mem_req_valid;
	logic              mem_ack;
	bus_pkg::mem_rsp_s mem_rsp;

	logic [31:0] ref_mem [logic [29:0]]; // words the CPU has written
	logic [31:0] lfsr_q;

	cache_top i_cache_top (
		.clk             (clk),
		.arst_n_i        (arst_n),
		.cpu_req_i       (cpu_req),
		.cpu_req_valid_i (cpu_req_valid),
		.cpu_ack_o       (cpu_ack),
		.cpu_rsp_o       (cpu_rsp),
		.mem_req_o       (mem_req),
		.mem_req_valid_o (mem_req_valid),
		.mem_ack_i       (mem_ack),
		.mem_rsp_i       (mem_rsp)
	);

	tb_cache_mem i_line_mem (
		.clk             (clk),
		.mem_req_i       (mem_req),
		.mem_req_valid_i (mem_req_valid),
		.mem_ack_o       (mem_ack),
		.mem_rsp_o       (mem_rsp)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] pattern_word(logic [31:0] addr);
		return {addr[15:0], addr[31:16]} ^ 32'h6b2dc5a7; // same fill as the memory
	endfunction

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_q[0]};
			lfsr_q = lfsr_next(lfsr_q);
		end
	endtask

	function automatic logic [31:0] ref_word(logic [31:0] addr);
		if (ref_mem.exists(addr[31:2])) begin
			return ref_mem[addr[31:2]];
		end
		return pattern_word(addr);
	endfunction

	function automatic logic [31:0] make_addr(logic [23:0] tag, logic [2:0] set, logic [2:0] word);
		return {tag, set, word, 2'b00};
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else report_failure($sformatf(
			"Error at %0d ns: %s is %08h, expected %08h", $time, what, got, exp));
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		assert (got == exp) else report_failure($sformatf(
			"Error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp));
	endtask

	// one four-phase exchange starting 1 ns after a rising edge
	task automatic cpu_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] be, output logic [31:0] rdata);
		int waited;
		cpu_req.write    = wr;
		cpu_req.addr.raw = addr;
		cpu_req.wdata    = wdata;
		cpu_req.be       = be;
		cpu_req_valid    = 1'b1;
		waited = 0;
		do begin
			@(posedge clk);
			#1;
			waited++;
		end while (!cpu_ack && waited < ACK_TIMEOUT);
		assert (cpu_ack) else report_failure("timeout: the cache never acknowledged the CPU");
		rdata = cpu_rsp.rdata;
		cpu_req_valid = 1'b0;
		waited = 0;
		do begin
			@(posedge clk);
			#1;
			waited++;
		end while (cpu_ack && waited < ACK_TIMEOUT);
		assert (!cpu_ack) else report_failure("timeout: the cache kept its ack high");
		assert (!i_line_mem.proto_err) else report_failure("memory request held after memory ack");
	endtask

	task automatic cpu_write(input logic [31:0] addr, input logic [31:0] data, input logic [3:0] be);
		logic [31:0] unused;
		logic [31:0] word;
		cpu_xfer(1'b1, addr, data, be, unused);
		word = ref_word(addr);
		for (int b = 0; b < 4; b++) begin
			if (be[b]) begin
				word[8*b +: 8] = data[8*b +: 8];
			end
		end
		ref_mem[addr[31:2]] = word;
	endtask

	task automatic read_check(input logic [31:0] addr);
		logic [31:0] got;
		cpu_xfer(1'b0, addr, 32'h0, 4'h0, got);
		check_value($sformatf("read of %08h", addr), got, ref_word(addr));
	endtask

	// whole evicted line against the reference
	task automatic check_wb_line();
		for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
			check_value("written-back word", i_line_mem.last_wb_line[32*w +: 32],
				ref_word(i_line_mem.last_wb_addr + 4*w));
		end
	endtask

	task automatic test_after_reset();
		logic [31:0] addr;
		int          rd0;
		int          wb0;
		addr = make_addr(24'h00a512, 3'd1, 3'd3);
		assert (!cpu_ack && !mem_req_valid) else report_failure("handshake outputs high after reset");
		rd0 = i_line_mem.rd_count;
		wb0 = i_line_mem.wb_count;
		read_check(addr);
		check_count("memory reads", i_line_mem.rd_count, rd0 + 1);
		check_value("refill address", i_line_mem.last_rd_addr, addr & 32'hffffffe0);
		check_count("write-backs", i_line_mem.wb_count, wb0);
	endtask

	task automatic test_write_hit();
		logic [31:0] addr;
		int          xfers;
		addr  = make_addr(24'h00a512, 3'd1, 3'd3); // resident since the first read
		xfers = i_line_mem.xfer_count;
		cpu_write(addr, 32'hc3d2e1f0, 4'b1010);
		read_check(addr);
		read_check(addr + 4);
		check_count("memory transfers", i_line_mem.xfer_count, xfers);
	endtask

	task automatic test_dirty_eviction();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		int          rd0;
		int          wb0;
		a = make_addr(24'h001100, 3'd5, 3'd2);
		b = make_addr(24'h002200, 3'd5, 3'd2);
		c = make_addr(24'h003300, 3'd5, 3'd2);
		cpu_write(a, 32'h13579bdf, 4'b0110);
		read_check(b);
		wb0 = i_line_mem.wb_count;
		read_check(c); // a is LRU and dirty
		check_count("write-backs", i_line_mem.wb_count, wb0 + 1);
		check_value("write-back address", i_line_mem.last_wb_addr, a & 32'hffffffe0);
		check_wb_line();
		check_value("refill address", i_line_mem.last_rd_addr, c & 32'hffffffe0);
		assert (i_line_mem.last_wb_seq < i_line_mem.last_rd_seq) else
			report_failure("the refill was issued before the dirty line was written back");
		rd0 = i_line_mem.rd_count;
		read_check(a);
		check_count("memory reads", i_line_mem.rd_count, rd0 + 1);
	endtask

	task automatic test_lru_order();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		int          rd0;
		a = make_addr(24'h004400, 3'd6, 3'd0);
		b = make_addr(24'h005500, 3'd6, 3'd7);
		c = make_addr(24'h006600, 3'd6, 3'd4);
		read_check(a);
		read_check(b);
		rd0 = i_line_mem.rd_count;
		read_check(a); // this hit leaves b as LRU
		check_count("memory reads", i_line_mem.rd_count, rd0);
		read_check(c);
		check_value("refill address", i_line_mem.last_rd_addr, c & 32'hffffffe0);
		rd0 = i_line_mem.rd_count;
		read_check(a);
		check_count("memory reads", i_line_mem.rd_count, rd0);
		read_check(b);
		check_count("memory reads", i_line_mem.rd_count, rd0 + 1);
	endtask

	task automatic test_random();
		logic [31:0] wr_bits;
		logic [31:0] tag_bits;
		logic [31:0] set_bits;
		logic [31:0] word_bits;
		logic [31:0] be_bits;
		logic [31:0] data;
		logic [31:0] addr;
		int          wb0;
		for (int n = 0; n < 200; n++) begin
			draw_bits(1, wr_bits);
			draw_bits(2, tag_bits);
			draw_bits(2, set_bits);
			draw_bits(3, word_bits);
			draw_bits(4, be_bits);
			draw_bits(32, data);
			addr = make_addr({22'h3a5c11, tag_bits[1:0]}, {1'b0, set_bits[1:0]}, word_bits[2:0]);
			wb0  = i_line_mem.wb_count;
			if (wr_bits[0]) begin
				cpu_write(addr, data, be_bits[3:0]);
			end else begin
				read_check(addr);
			end
			if (i_line_mem.wb_count != wb0) begin
				check_wb_line();
			end
		end
	endtask

	initial begin
		clk           = 1'b0;
		arst_n        = 1'b0;
		cpu_req       = '0;
		cpu_req_valid = 1'b0;
		lfsr_q        = 32'h81d83a91;
		repeat (3) @(posedge clk);
		#1;
		arst_n = 1'b1;
		test_after_reset();
		test_write_hit();
		test_dirty_eviction();
		test_lru_order();
		test_random();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule
